/* verilog/id_pkg.sv */
package id_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       xlen_t;      // register value or immediate
    typedef logic [31:0]           instr_t;     // raw instruction word
    typedef logic [XLEN-1:0]       pc_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // x0..x31

    // ==================================================
    // major opcodes
    // ==================================================
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

    // ==================================================
    // control encodings
    // ==================================================
    // one-hot, one bit per ALU function
    typedef enum logic [17:0] {
        ALU_ADD    = 18'h00001,
        ALU_SUB    = 18'h00002,
        ALU_SLL    = 18'h00004,
        ALU_SLT    = 18'h00008,
        ALU_SLTU   = 18'h00010,
        ALU_XOR    = 18'h00020,
        ALU_SRL    = 18'h00040,
        ALU_SRA    = 18'h00080,
        ALU_OR     = 18'h00100,
        ALU_AND    = 18'h00200,
        ALU_MUL    = 18'h00400,
        ALU_MULH   = 18'h00800,
        ALU_MULHSU = 18'h01000,
        ALU_MULHU  = 18'h02000,
        ALU_DIV    = 18'h04000,
        ALU_DIVU   = 18'h08000,
        ALU_REM    = 18'h10000,
        ALU_REMU   = 18'h20000
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_type_e;

    typedef enum logic [3:0] {
        DMEM_NONE, DMEM_LB, DMEM_LH, DMEM_LW, DMEM_LBU, DMEM_LHU,
        DMEM_SB, DMEM_SH, DMEM_SW
    } dmem_type_e;

    typedef enum logic [3:0] {
        WB_ALU = 4'b0001,
        WB_MEM = 4'b0010,
        WB_IMM = 4'b0100,
        WB_PC  = 4'b1000
    } wb_src_e;

    typedef enum logic {RS1_RF, RS1_PC} rs1_sel_e;   // operand a
    typedef enum logic {RS2_RF, RS2_IMM} rs2_sel_e;  // operand b

    // ==================================================
    // stage bundles
    // ==================================================
    typedef struct packed {
        alu_op_e    alu_op;
        rs1_sel_e   rs1_sel;
        rs2_sel_e   rs2_sel;
        imm_type_e  imm_type;
        logic       beq;
        logic       blt;
        logic       branch_b;
        logic       branch_jal;
        logic       branch_jalr;
        dmem_type_e dmem_type;
        wb_src_e    wb_src;
        logic       wb_en;
        logic       illegal;
    } id_ctrl_t;

    typedef struct packed {
        pc_t    pc;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        pc_t       pc;
        id_ctrl_t  ctrl;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        xlen_t     imm;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        xlen_t     data;
    } wb_req_t;

endpackage

/* verilog/decoder.sv */
`timescale 1ns/1ns

module decoder (
    input  id_pkg::instr_t   instruction_i,
    output id_pkg::id_ctrl_t ctrl_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b30;  // sub / sra select
    logic       funct7_b25;  // M extension group

    assign opcode     = instruction_i[6:0];
    assign funct3     = instruction_i[14:12];
    assign funct7_b30 = instruction_i[30];
    assign funct7_b25 = instruction_i[25];

    always_comb begin
        // ==================================================
        // defaults
        // ==================================================
        ctrl_o.alu_op      = id_pkg::ALU_ADD;
        ctrl_o.rs1_sel     = id_pkg::RS1_RF;
        ctrl_o.rs2_sel     = id_pkg::RS2_IMM;
        ctrl_o.imm_type    = id_pkg::IMM_NONE;
        ctrl_o.beq         = 1'b0;
        ctrl_o.blt         = 1'b0;
        ctrl_o.branch_b    = 1'b0;
        ctrl_o.branch_jal  = 1'b0;
        ctrl_o.branch_jalr = 1'b0;
        ctrl_o.dmem_type   = id_pkg::DMEM_NONE;
        ctrl_o.wb_src      = id_pkg::WB_ALU;
        ctrl_o.wb_en       = 1'b1;
        ctrl_o.illegal     = 1'b0;

        // ==================================================
        // per opcode
        // ==================================================
        case (opcode)
            id_pkg::OPCODE_LOAD: begin
                ctrl_o.imm_type = id_pkg::IMM_I;  // base + offset
                ctrl_o.wb_src   = id_pkg::WB_MEM;
                case (funct3)
                    3'b000:  ctrl_o.dmem_type = id_pkg::DMEM_LB;
                    3'b001:  ctrl_o.dmem_type = id_pkg::DMEM_LH;
                    3'b010:  ctrl_o.dmem_type = id_pkg::DMEM_LW;
                    3'b100:  ctrl_o.dmem_type = id_pkg::DMEM_LBU;
                    3'b101:  ctrl_o.dmem_type = id_pkg::DMEM_LHU;
                    default: ctrl_o.illegal   = 1'b1;  // 3, 6, 7
                endcase
            end
            id_pkg::OPCODE_OP_IMM: begin
                ctrl_o.imm_type = id_pkg::IMM_I;
                case (funct3)
                    3'b000:  ctrl_o.alu_op = id_pkg::ALU_ADD;   // addi
                    3'b001:  ctrl_o.alu_op = id_pkg::ALU_SLL;   // slli
                    3'b010:  ctrl_o.alu_op = id_pkg::ALU_SLT;   // slti
                    3'b011:  ctrl_o.alu_op = id_pkg::ALU_SLTU;  // sltiu
                    3'b100:  ctrl_o.alu_op = id_pkg::ALU_XOR;   // xori
                    3'b101:  ctrl_o.alu_op = funct7_b30 ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
                    3'b110:  ctrl_o.alu_op = id_pkg::ALU_OR;    // ori
                    default: ctrl_o.alu_op = id_pkg::ALU_AND;   // andi
                endcase
            end
            id_pkg::OPCODE_AUIPC: begin
                ctrl_o.imm_type = id_pkg::IMM_U;
                ctrl_o.rs1_sel  = id_pkg::RS1_PC;  // pc + upper imm
            end
            id_pkg::OPCODE_STORE: begin
                ctrl_o.imm_type = id_pkg::IMM_S;
                ctrl_o.wb_en    = 1'b0;
                case (funct3)
                    3'b000:  ctrl_o.dmem_type = id_pkg::DMEM_SB;
                    3'b001:  ctrl_o.dmem_type = id_pkg::DMEM_SH;
                    3'b010:  ctrl_o.dmem_type = id_pkg::DMEM_SW;
                    default: ctrl_o.illegal   = 1'b1;
                endcase
            end
            id_pkg::OPCODE_RTYPE: begin
                ctrl_o.rs2_sel = id_pkg::RS2_RF;  // no immediate
                if (funct7_b25) begin
                    // multiply / divide group
                    case (funct3)
                        3'b000:  ctrl_o.alu_op = id_pkg::ALU_MUL;
                        3'b001:  ctrl_o.alu_op = id_pkg::ALU_MULH;
                        3'b010:  ctrl_o.alu_op = id_pkg::ALU_MULHSU;
                        3'b011:  ctrl_o.alu_op = id_pkg::ALU_MULHU;
                        3'b100:  ctrl_o.alu_op = id_pkg::ALU_DIV;
                        3'b101:  ctrl_o.alu_op = id_pkg::ALU_DIVU;
                        3'b110:  ctrl_o.alu_op = id_pkg::ALU_REM;
                        default: ctrl_o.alu_op = id_pkg::ALU_REMU;
                    endcase
                end else begin
                    case (funct3)
                        3'b000:  ctrl_o.alu_op = funct7_b30 ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
                        3'b001:  ctrl_o.alu_op = id_pkg::ALU_SLL;
                        3'b010:  ctrl_o.alu_op = id_pkg::ALU_SLT;
                        3'b011:  ctrl_o.alu_op = id_pkg::ALU_SLTU;
                        3'b100:  ctrl_o.alu_op = id_pkg::ALU_XOR;
                        3'b101:  ctrl_o.alu_op = funct7_b30 ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
                        3'b110:  ctrl_o.alu_op = id_pkg::ALU_OR;
                        default: ctrl_o.alu_op = id_pkg::ALU_AND;
                    endcase
                end
            end
            id_pkg::OPCODE_LUI: begin
                ctrl_o.imm_type = id_pkg::IMM_U;
                ctrl_o.wb_src   = id_pkg::WB_IMM;  // imm straight to rd
            end
            id_pkg::OPCODE_BRANCH: begin
                ctrl_o.imm_type = id_pkg::IMM_B;
                ctrl_o.branch_b = 1'b1;
                ctrl_o.rs1_sel  = id_pkg::RS1_PC;
                ctrl_o.wb_en    = 1'b0;
                case (funct3)
                    3'b000: begin  // beq
                        ctrl_o.alu_op = id_pkg::ALU_SUB;
                        ctrl_o.beq    = 1'b1;
                    end
                    3'b001: ctrl_o.alu_op = id_pkg::ALU_SUB;  // bne
                    3'b100: begin  // blt
                        ctrl_o.alu_op = id_pkg::ALU_SLT;
                        ctrl_o.blt    = 1'b1;
                    end
                    3'b101: ctrl_o.alu_op = id_pkg::ALU_SLT;  // bge
                    3'b110: begin  // bltu
                        ctrl_o.alu_op = id_pkg::ALU_SLTU;
                        ctrl_o.blt    = 1'b1;
                    end
                    3'b111:  ctrl_o.alu_op  = id_pkg::ALU_SLTU;  // bgeu
                    default: ctrl_o.illegal = 1'b1;             // 2, 3
                endcase
            end
            id_pkg::OPCODE_JALR: begin
                ctrl_o.imm_type    = id_pkg::IMM_I;
                ctrl_o.branch_jalr = 1'b1;
                ctrl_o.wb_src      = id_pkg::WB_PC;  // link address
            end
            id_pkg::OPCODE_JAL: begin
                ctrl_o.imm_type   = id_pkg::IMM_J;
                ctrl_o.branch_jal = 1'b1;
                ctrl_o.rs1_sel    = id_pkg::RS1_PC;
                ctrl_o.wb_src     = id_pkg::WB_PC;
            end
            default: ctrl_o.illegal = 1'b1;  // unknown opcode
        endcase
    end

endmodule

/* verilog/imm_extend.sv */
`timescale 1ns/1ns

module imm_extend (
    input  id_pkg::instr_t    instruction_i,
    input  id_pkg::imm_type_e imm_type_i,
    output id_pkg::xlen_t     imm_o
);

    logic sign;

    assign sign = instruction_i[31];  // every format signs from bit 31

    always_comb begin
        case (imm_type_i)
            id_pkg::IMM_I: begin
                imm_o = {{20{sign}}, instruction_i[31:20]};
            end
            id_pkg::IMM_S: begin
                imm_o = {{20{sign}}, instruction_i[31:25], instruction_i[11:7]};
            end
            id_pkg::IMM_B: begin
                imm_o = {{19{sign}}, instruction_i[31], instruction_i[7],
                         instruction_i[30:25], instruction_i[11:8], 1'b0};
            end
            id_pkg::IMM_U: begin
                imm_o = {instruction_i[31:12], 12'b0};  // low bits zero
            end
            id_pkg::IMM_J: begin
                imm_o = {{11{sign}}, instruction_i[31], instruction_i[19:12],
                         instruction_i[20], instruction_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;  // no immediate
            end
        endcase
    end

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ns

module regfile (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  id_pkg::reg_addr_t rs1_addr_i,
    input  id_pkg::reg_addr_t rs2_addr_i,
    output id_pkg::xlen_t     rs1_data_o,
    output id_pkg::xlen_t     rs2_data_o,
    input  id_pkg::wb_req_t   wb_i
);

    id_pkg::xlen_t regs [id_pkg::NUM_REGS-1:1];  // x0 has no storage

    // ==================================================
    // write port
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < id_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.en && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // ==================================================
    // read ports
    // ==================================================
    function automatic id_pkg::xlen_t read_reg(id_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_i.en && wb_i.rd == addr) begin
            return wb_i.data;  // same-cycle write passes through
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_reg(rs1_addr_i);
        rs2_data_o = read_reg(rs2_addr_i);
    end

endmodule

/* verilog/id_stage.sv */
`timescale 1ns/1ns

module id_stage (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // fetch side
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  id_pkg::if_id_t  if_id_i,

    // execute side
    output logic            out_valid_o,
    input  logic            out_ready_i,
    output id_pkg::id_ex_t  id_ex_o,

    // writeback from later stages
    input  id_pkg::wb_req_t wb_i
);

    id_pkg::id_ctrl_t  ctrl;
    id_pkg::xlen_t     imm;
    id_pkg::xlen_t     rs1_data;
    id_pkg::xlen_t     rs2_data;
    id_pkg::reg_addr_t rs1_addr;
    id_pkg::reg_addr_t rs2_addr;
    id_pkg::id_ex_t    id_ex_d;
    id_pkg::id_ex_t    id_ex_q;
    logic              out_valid_q;
    logic              accept;

    // ==================================================
    // decode
    // ==================================================
    assign rs1_addr = if_id_i.instr[19:15];
    assign rs2_addr = if_id_i.instr[24:20];

    decoder decoder_inst (
        .instruction_i (if_id_i.instr),
        .ctrl_o        (ctrl)
    );

    imm_extend imm_extend_inst (
        .instruction_i (if_id_i.instr),
        .imm_type_i    (ctrl.imm_type),  // format picked by the decoder
        .imm_o         (imm)
    );

    regfile regfile_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_i)
    );

    always_comb begin
        id_ex_d.pc       = if_id_i.pc;
        id_ex_d.ctrl     = ctrl;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm;
        id_ex_d.rd       = if_id_i.instr[11:7];
    end

    // ==================================================
    // ID/EX register and handshakes
    // ==================================================
    // room when empty or when execute drains this cycle
    assign in_ready_o = ~out_valid_q | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_q <= in_valid_i;  // refill or go empty
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            id_ex_q <= id_ex_d;
        end
    end

    assign out_valid_o = out_valid_q;
    assign id_ex_o     = id_ex_q;

endmodule

/* sim/tb_id_model.svh */
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// ==================================================
// stimulus source
// ==================================================
// 16-bit Fibonacci LFSR, x^16 + x^15 + x^13 + x^4 + 1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb     = lfsr_q[15] ^ lfsr_q[14] ^ lfsr_q[12] ^ lfsr_q[3];
        lfsr_q = {lfsr_q[14:0], fb};
        r      = {r[30:0], fb};
    end
    return r;
endfunction

// ==================================================
// expected immediate
// ==================================================
function automatic id_pkg::xlen_t model_imm(input id_pkg::instr_t ins);
    logic [31:0] v;
    v = '0;
    case (ins[6:0])
        id_pkg::OPCODE_LOAD, id_pkg::OPCODE_OP_IMM, id_pkg::OPCODE_JALR: begin
            v[11:0] = ins[31:20];
            v       = 32'($signed(v << 20) >>> 20);
        end
        id_pkg::OPCODE_STORE: begin
            v[11:5] = ins[31:25];
            v[4:0]  = ins[11:7];
            v       = 32'($signed(v << 20) >>> 20);
        end
        id_pkg::OPCODE_BRANCH: begin
            v[12]   = ins[31];
            v[11]   = ins[7];
            v[10:5] = ins[30:25];
            v[4:1]  = ins[11:8];
            v       = 32'($signed(v << 19) >>> 19);
        end
        id_pkg::OPCODE_LUI, id_pkg::OPCODE_AUIPC: begin
            v[31:12] = ins[31:12];
        end
        id_pkg::OPCODE_JAL: begin
            v[20]    = ins[31];
            v[19:12] = ins[19:12];
            v[11]    = ins[20];
            v[10:1]  = ins[30:21];
            v        = 32'($signed(v << 11) >>> 11);
        end
        default: v = '0;  // R-type and unknown opcodes
    endcase
    return v;
endfunction

// ==================================================
// expected register read, with same-cycle bypass
// ==================================================
function automatic id_pkg::xlen_t model_read(input id_pkg::reg_addr_t a);
    if (a == 5'd0) begin
        return '0;
    end
    if (wb_i.en && wb_i.rd == a) begin
        return wb_i.data;
    end
    return shadow[a];
endfunction

`endif

/* sim/tb_id_ctrl.svh */
`ifndef TB_ID_CTRL_SVH
`define TB_ID_CTRL_SVH

// ==================================================
// expected control bundle
// ==================================================
function automatic id_pkg::alu_op_e base_op(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
        3'd1:    return id_pkg::ALU_SLL;
        3'd2:    return id_pkg::ALU_SLT;
        3'd3:    return id_pkg::ALU_SLTU;
        3'd4:    return id_pkg::ALU_XOR;
        3'd5:    return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
        3'd6:    return id_pkg::ALU_OR;
        default: return id_pkg::ALU_AND;
    endcase
endfunction

function automatic id_pkg::alu_op_e m_op(input logic [2:0] f3);
    id_pkg::alu_op_e t [8];
    t = '{id_pkg::ALU_MUL, id_pkg::ALU_MULH, id_pkg::ALU_MULHSU, id_pkg::ALU_MULHU,
          id_pkg::ALU_DIV, id_pkg::ALU_DIVU, id_pkg::ALU_REM, id_pkg::ALU_REMU};
    return t[f3];
endfunction

function automatic id_pkg::id_ctrl_t model_ctrl(input id_pkg::instr_t ins);
    id_pkg::id_ctrl_t c;
    logic [2:0] f3;
    f3 = ins[14:12];
    c  = '{alu_op: id_pkg::ALU_ADD, rs1_sel: id_pkg::RS1_RF, rs2_sel: id_pkg::RS2_IMM,
           imm_type: id_pkg::IMM_NONE, beq: 1'b0, blt: 1'b0, branch_b: 1'b0,
           branch_jal: 1'b0, branch_jalr: 1'b0, dmem_type: id_pkg::DMEM_NONE,
           wb_src: id_pkg::WB_ALU, wb_en: 1'b1, illegal: 1'b0};
    case (ins[6:0])
        id_pkg::OPCODE_LOAD: begin
            c.imm_type = id_pkg::IMM_I;
            c.wb_src   = id_pkg::WB_MEM;
            case (f3)
                3'd0:    c.dmem_type = id_pkg::DMEM_LB;
                3'd1:    c.dmem_type = id_pkg::DMEM_LH;
                3'd2:    c.dmem_type = id_pkg::DMEM_LW;
                3'd4:    c.dmem_type = id_pkg::DMEM_LBU;
                3'd5:    c.dmem_type = id_pkg::DMEM_LHU;
                default: c.illegal   = 1'b1;
            endcase
        end
        id_pkg::OPCODE_OP_IMM: begin
            c.imm_type = id_pkg::IMM_I;
            c.alu_op   = base_op(f3, ins[30] && f3 == 3'd5);  // no subi
        end
        id_pkg::OPCODE_AUIPC: begin
            c.imm_type = id_pkg::IMM_U;
            c.rs1_sel  = id_pkg::RS1_PC;
        end
        id_pkg::OPCODE_STORE: begin
            c.imm_type = id_pkg::IMM_S;
            c.wb_en    = 1'b0;
            if (f3 > 3'd2) begin
                c.illegal = 1'b1;
            end else begin
                c.dmem_type = id_pkg::dmem_type_e'(int'(id_pkg::DMEM_SB) + f3);
            end
        end
        id_pkg::OPCODE_RTYPE: begin
            c.rs2_sel = id_pkg::RS2_RF;
            c.alu_op  = ins[25] ? m_op(f3) : base_op(f3, ins[30]);
        end
        id_pkg::OPCODE_LUI: begin
            c.imm_type = id_pkg::IMM_U;
            c.wb_src   = id_pkg::WB_IMM;
        end
        id_pkg::OPCODE_BRANCH: begin
            c.imm_type = id_pkg::IMM_B;
            c.branch_b = 1'b1;
            c.rs1_sel  = id_pkg::RS1_PC;
            c.wb_en    = 1'b0;
            c.illegal  = (f3 == 3'd2) || (f3 == 3'd3);
            if (!c.illegal) begin
                c.alu_op = !f3[2] ? id_pkg::ALU_SUB : (f3[1] ? id_pkg::ALU_SLTU : id_pkg::ALU_SLT);
                c.beq    = (f3 == 3'd0);
                c.blt    = f3[2] && !f3[0];  // blt and bltu
            end
        end
        id_pkg::OPCODE_JALR: begin
            c.imm_type    = id_pkg::IMM_I;
            c.branch_jalr = 1'b1;
            c.wb_src      = id_pkg::WB_PC;
        end
        id_pkg::OPCODE_JAL: begin
            c.imm_type   = id_pkg::IMM_J;
            c.branch_jal = 1'b1;
            c.rs1_sel    = id_pkg::RS1_PC;
            c.wb_src     = id_pkg::WB_PC;
        end
        default: c.illegal = 1'b1;
    endcase
    return c;
endfunction

// ==================================================
// random instruction words
// ==================================================
function automatic id_pkg::instr_t rand_legal();
    id_pkg::instr_t ins;
    logic [6:0] ops [9];
    logic [2:0] ld_f3 [5];
    logic [2:0] br_f3 [6];
    ops   = '{id_pkg::OPCODE_LOAD, id_pkg::OPCODE_OP_IMM, id_pkg::OPCODE_AUIPC,
              id_pkg::OPCODE_STORE, id_pkg::OPCODE_RTYPE, id_pkg::OPCODE_LUI,
              id_pkg::OPCODE_BRANCH, id_pkg::OPCODE_JALR, id_pkg::OPCODE_JAL};
    ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ins       = rand_bits(32);
    ins[6:0]  = ops[rand_bits(4) % 9];
    case (ins[6:0])
        id_pkg::OPCODE_LOAD:   ins[14:12] = ld_f3[rand_bits(3) % 5];
        id_pkg::OPCODE_STORE:  ins[14:12] = 3'(rand_bits(2) % 3);
        id_pkg::OPCODE_BRANCH: ins[14:12] = br_f3[rand_bits(3) % 6];
        default: ;
    endcase
    return ins;
endfunction

function automatic id_pkg::instr_t rand_illegal();
    id_pkg::instr_t ins;
    logic [1:0] kind;
    logic [2:0] bad_ld [3];
    logic [6:0] bad_op [4];
    bad_ld = '{3'd3, 3'd6, 3'd7};
    bad_op = '{7'b0001011, 7'b0101011, 7'b1011011, 7'b1111011};
    ins  = rand_bits(32);
    kind = 2'(rand_bits(2));
    case (kind)
        2'd0: begin
            ins[6:0]   = id_pkg::OPCODE_LOAD;
            ins[14:12] = bad_ld[rand_bits(2) % 3];
        end
        2'd1: begin
            ins[6:0]   = id_pkg::OPCODE_STORE;
            ins[14:12] = 3'd3 + 3'(rand_bits(3) % 5);  // 3..7
        end
        2'd2: begin
            ins[6:0]   = id_pkg::OPCODE_BRANCH;
            ins[14:12] = {2'b01, 1'(rand_bits(1))};     // 2 or 3
        end
        default: begin
            ins[6:0] = bad_op[2'(rand_bits(2))];  // custom space
        end
    endcase
    return ins;
endfunction

`endif

/* sim/tb_id_stage.sv */
`timescale 1ns/1ns

module tb_id_stage;

    localparam int N_INSTR = 16 + 40 + 200 + 40 + 120;  // sends over all tests

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic              in_valid_i;
    logic              in_ready_o;
    id_pkg::if_id_t    if_id_i;
    logic              out_valid_o;
    logic              out_ready_i;
    id_pkg::id_ex_t    id_ex_o;
    id_pkg::wb_req_t   wb_i;

    logic [15:0]       lfsr_q = 16'd85;
    id_pkg::xlen_t     shadow [32];
    id_pkg::id_ex_t    exp_q [$];
    id_pkg::id_ex_t    last_exp;
    logic              acc_prev = 1'b0;
    logic              bp_mode  = 1'b0;   // random out_ready_i
    id_pkg::pc_t       pc_q     = 32'h0000_1000;
    int                err_cnt  = 0;
    int                chk_cnt  = 0;
    int                test_cnt = 0;

    `include "tb_id_model.svh"
    `include "tb_id_ctrl.svh"

    id_stage id_stage_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .if_id_i     (if_id_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .id_ex_o     (id_ex_o),
        .wb_i        (wb_i)
    );

    always #50 clk_i = ~clk_i;  // 100 ns period

    // ==================================================
    // checks
    // ==================================================
    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        chk_cnt++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic compare_bundle(input id_pkg::id_ex_t exp, input id_pkg::id_ex_t got);
        check_val("id_ex_o.pc", 64'(exp.pc), 64'(got.pc));
        check_val("id_ex_o.ctrl", 64'(exp.ctrl), 64'(got.ctrl));
        check_val("id_ex_o.rs1_data", 64'(exp.rs1_data), 64'(got.rs1_data));
        check_val("id_ex_o.rs2_data", 64'(exp.rs2_data), 64'(got.rs2_data));
        check_val("id_ex_o.imm", 64'(exp.imm), 64'(got.imm));
        check_val("id_ex_o.rd", 64'(exp.rd), 64'(got.rd));
    endtask

    // held output while execute stalls
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(id_ex_o)))
        else begin
            $display("[FAIL] %0t ns id_ex_o changed while execute stalled", $time);
            err_cnt++;
        end

    // scoreboard sampled mid-cycle, where every input and output is settled
    always @(negedge clk_i) begin
        id_pkg::id_ex_t exp;
        if (rst_n_i) begin
            if (acc_prev) begin  // one cycle latency
                check_val("out_valid_o", 64'd1, 64'(out_valid_o));
                check_val("id_ex_o.ctrl", 64'(last_exp.ctrl), 64'(id_ex_o.ctrl));
                check_val("id_ex_o.pc", 64'(last_exp.pc), 64'(id_ex_o.pc));
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("execute took a bundle that fetch never sent at %0t ns", $time);
                    err_cnt++;
                end else begin
                    compare_bundle(exp_q.pop_front(), id_ex_o);
                end
            end
            acc_prev = in_valid_i && in_ready_o;
            if (acc_prev) begin
                exp.pc       = if_id_i.pc;
                exp.ctrl     = model_ctrl(if_id_i.instr);
                exp.rs1_data = model_read(if_id_i.instr[19:15]);
                exp.rs2_data = model_read(if_id_i.instr[24:20]);
                exp.imm      = model_imm(if_id_i.instr);
                exp.rd       = if_id_i.instr[11:7];
                exp_q.push_back(exp);
                last_exp = exp;
            end
            if (wb_i.en && wb_i.rd != 5'd0) begin
                shadow[wb_i.rd] = wb_i.data;  // lands at the next edge
            end
        end
    end

    // ==================================================
    // stimulus
    // ==================================================
    task automatic drive_ready();
        if (bp_mode) begin
            out_ready_i <= 1'(rand_bits(1));
        end else begin
            out_ready_i <= 1'b1;
        end
    endtask

    task automatic send(input id_pkg::instr_t instr, input id_pkg::wb_req_t wb);
        @(posedge clk_i);
        drive_ready();
        in_valid_i    <= 1'b1;
        if_id_i.pc    <= pc_q;
        if_id_i.instr <= instr;
        wb_i          <= wb;
        pc_q = pc_q + 32'd4;
        @(negedge clk_i);
        while (!in_ready_o) begin  // stalled by a full register
            @(posedge clk_i);
            drive_ready();
            @(negedge clk_i);
        end
        @(posedge clk_i);  // transfer edge
        drive_ready();
        in_valid_i <= 1'b0;
        wb_i.en    <= 1'b0;
    endtask

    function automatic id_pkg::instr_t rtype(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, id_pkg::OPCODE_RTYPE};
    endfunction

    function automatic id_pkg::wb_req_t no_wb();
        return '{en: 1'b0, rd: 5'd0, data: '0};
    endfunction

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %-12s done, %0d errors", name, err_cnt - errs_before);
    endtask

    initial begin
        int e;
        id_pkg::wb_req_t wb;
        logic [4:0] r;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;  // ready then comes only from the empty register
        if_id_i     = '0;
        wb_i        = '0;

        // reset
        e = err_cnt;
        @(posedge clk_i);
        repeat (15) begin
            @(negedge clk_i);
            check_val("out_valid_o", 64'd0, 64'(out_valid_o));
            check_val("in_ready_o", 64'd1, 64'(in_ready_o));
            @(posedge clk_i);
        end
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_val("out_valid_o", 64'd0, 64'(out_valid_o));
        check_val("in_ready_o", 64'd1, 64'(in_ready_o));
        for (int i = 0; i < 16; i++) begin  // every register reads zero
            send(rtype(5'd1, 5'(2 * i), 5'(2 * i + 1)), no_wb());
        end
        finish_test("reset", e);

        // register reads with writes through wb_i
        e = err_cnt;
        send(rtype(5'd3, 5'd0, 5'd0), '{en: 1'b1, rd: 5'd0, data: 32'hdead_beef});
        send(rtype(5'd3, 5'd0, 5'd0), no_wb());
        send(rtype(5'd3, 5'd7, 5'd7), '{en: 1'b1, rd: 5'd7, data: 32'h1234_5678});
        for (int i = 0; i < 37; i++) begin
            wb.en   = 1'(rand_bits(1));
            wb.rd   = 5'(rand_bits(5));
            wb.data = rand_bits(32);
            r       = rand_bits(1) ? wb.rd : 5'(rand_bits(5));  // often the written one
            send(rtype(5'(rand_bits(5)), r, 5'(rand_bits(5))), wb);
        end
        finish_test("regread", e);

        // control and immediates over all nine opcodes
        e = err_cnt;
        for (int i = 0; i < 200; i++) begin
            send(rand_legal(), no_wb());
        end
        finish_test("decode_imm", e);

        // illegal encodings
        e = err_cnt;
        for (int i = 0; i < 40; i++) begin
            send(rand_illegal(), no_wb());
        end
        finish_test("illegal", e);

        // random back-pressure from execute
        e = err_cnt;
        bp_mode = 1'b1;
        for (int i = 0; i < 120; i++) begin
            wb.en   = 1'(rand_bits(1));
            wb.rd   = 5'(rand_bits(5));
            wb.data = rand_bits(32);
            send(rand_legal(), wb);
        end
        bp_mode = 1'b0;
        @(posedge clk_i);
        out_ready_i <= 1'b1;
        while (exp_q.size() != 0 || out_valid_o) begin
            @(negedge clk_i);
        end
        finish_test("backpressure", e);

        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // ==================================================
    // watchdog
    // ==================================================
    initial begin
        #((N_INSTR * 4 + 200) * 100);
        $display("timeout, the tests did not finish in %0d cycles", N_INSTR * 4 + 200);
        $display("Errors found");
        $finish;
    end

endmodule

/* tb.f */
+incdir+sim
verilog/id_pkg.sv
verilog/decoder.sv
verilog/imm_extend.sv
verilog/regfile.sv
verilog/id_stage.sv
sim/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - files:
      - verilog/id_pkg.sv
      - verilog/decoder.sv
      - verilog/imm_extend.sv
      - verilog/regfile.sv
      - verilog/id_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_id_stage.sv
